//--- hdl/video_pkg.sv
// shared raster sizes, mode codes and video types; referenced by scoped name from every module
package video_pkg;

	// raster size, kept tiny so a frame simulates quickly
	localparam int H_ACTIVE = 32;
	localparam int H_TOTAL  = 48;
	localparam int V_ACTIVE = 8;
	localparam int V_TOTAL  = 12;

	// sync placement in pixels and lines, pulses are active high
	localparam int HSYNC_START = 36;
	localparam int HSYNC_LEN   = 4;
	localparam int VSYNC_START = 9;
	localparam int VSYNC_LEN   = 1;

	// one fetched word covers a group of 8 screen pixels
	localparam int GROUP_PIX = 8;
	localparam int GROUPS    = H_ACTIVE / GROUP_PIX;
	localparam int GROUP_W   = $clog2(GROUPS);

	localparam int MEM_AW = 8;
	localparam int HCNT_W = $clog2(H_TOTAL);
	localparam int VCNT_W = $clog2(V_TOTAL);

	typedef logic [HCNT_W-1:0]  hcnt_t;
	typedef logic [VCNT_W-1:0]  vcnt_t;
	typedef logic [GROUP_W-1:0] grp_t;
	typedef logic [MEM_AW-1:0]  mem_addr_t;

	typedef enum logic [1:0] {
		R_ZX = 2'h0,	// ZX bitmap with attributes
		R_HC = 2'h1,	// 16 colours, 4 bits per pixel
		R_XC = 2'h2,	// 256 colours, 8 bits per pixel
		R_TX = 2'h3	// text, ZX bitmap with nibble colours
	} render_mode_e;

	// zx view: attributes in the high half, bitmap in the low half
	typedef struct packed {
		logic [15:0] atr;
		logic [15:0] gfx;
	} zx_word_s;

	typedef union packed {
		zx_word_s        zx;
		logic [3:0][7:0] chunky;	// chunky[0] is the low byte
	} video_word_u;

	typedef struct packed {
		render_mode_e mode;
		logic         hires;
		logic         nogfx;
		logic         notsu;
		logic         flash;
		logic [3:0]   palsel;
		logic [7:0]   border;
	} video_cfg_s;

	typedef struct packed {
		logic       hvpix;	// inside the active area
		logic [3:0] psel;	// pixel select inside the current word
		logic       phase;	// high on even pixels
	} raster_s;

endpackage

//--- hdl/video_ctrl.sv
// raster timing generator used by the video output top for sync, de, pixel select and fetch strobes
module video_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  video_pkg::video_cfg_s cfg,
	output video_pkg::raster_s    raster,
	output logic                  fetch_req,
	output logic                  group_tick,
	output logic                  line_start,
	output logic                  hsync,
	output logic                  vsync,
	output logic                  de
);

	video_pkg::hcnt_t hcnt;
	video_pkg::vcnt_t vcnt;
	logic             hvpix;
	logic             hs_raw;
	logic             vs_raw;
	logic             next_line_act;
	logic             grp_first;
	logic [2:0]       sync_d1;	// {hsync, vsync, de}
	logic [2:0]       sync_d2;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (hcnt == video_pkg::hcnt_t'(video_pkg::H_TOTAL - 1)) begin
			hcnt <= '0;
			if (vcnt == video_pkg::vcnt_t'(video_pkg::V_TOTAL - 1))
				vcnt <= '0;
			else
				vcnt <= vcnt + 1'b1;
		end else begin
			hcnt <= hcnt + 1'b1;
		end
	end

	assign hvpix = (hcnt < video_pkg::hcnt_t'(video_pkg::H_ACTIVE)) &&
		(vcnt < video_pkg::vcnt_t'(video_pkg::V_ACTIVE));

	assign hs_raw = (hcnt >= video_pkg::hcnt_t'(video_pkg::HSYNC_START)) &&
		(hcnt < video_pkg::hcnt_t'(video_pkg::HSYNC_START + video_pkg::HSYNC_LEN));
	assign vs_raw = (vcnt >= video_pkg::vcnt_t'(video_pkg::VSYNC_START)) &&
		(vcnt < video_pkg::vcnt_t'(video_pkg::VSYNC_START + video_pkg::VSYNC_LEN));

	// pixel select inside the word repeats pixels 2x in 16c and 4x in 256c
	always_comb begin
		raster.hvpix = hvpix;
		raster.phase = ~hcnt[0];
		case (cfg.mode)
			video_pkg::R_HC: raster.psel = {2'b00, hcnt[2:1]};
			video_pkg::R_XC: raster.psel = {3'b000, hcnt[2]};
			// odd lines take the upper gfx byte and attribute
			default:         raster.psel = {vcnt[0], hcnt[2:0]};
		endcase
	end

	// first pixel of each group in the active area
	assign grp_first  = hvpix && (hcnt[2:0] == 3'd0);
	assign group_tick = grp_first;

	// high when the following line is an active one
	assign next_line_act = (vcnt == video_pkg::vcnt_t'(video_pkg::V_TOTAL - 1)) ||
		(vcnt < video_pkg::vcnt_t'(video_pkg::V_ACTIVE - 1));

	// request one group ahead so group 0 is fetched in the horizontal blank
	assign fetch_req = (grp_first &&
		(hcnt < video_pkg::hcnt_t'(video_pkg::H_ACTIVE - video_pkg::GROUP_PIX))) ||
		((hcnt == video_pkg::hcnt_t'(video_pkg::H_TOTAL - video_pkg::GROUP_PIX)) &&
		next_line_act);

	// fetch line begins once the active part is done
	assign line_start = (hcnt == video_pkg::hcnt_t'(video_pkg::H_ACTIVE));

	// matches the render and palette register stages
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_d1 <= '0;
			sync_d2 <= '0;
		end else begin
			sync_d1 <= {hs_raw, vs_raw, hvpix};
			sync_d2 <= sync_d1;
		end
	end

	assign {hsync, vsync, de} = sync_d2;

	// the ticked pixel is displayed two cycles later
	a_tick_active: assert property (@(posedge clk) disable iff (!rst_n)
		group_tick |-> ##2 de)
		else $error("group tick outside the active area");

	// every request is consumed exactly one group later
	a_req_ahead: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_req |-> ##(video_pkg::GROUP_PIX) group_tick)
		else $error("fetch request not followed by a group tick");

endmodule

//--- hdl/video_fetch.sv
// video word fetcher: reads memory one group ahead and double-buffers the returned words
module video_fetch (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   fetch_req,
	input  logic                   group_tick,
	input  logic                   line_start,
	input  logic                   vsync,
	output logic                   mem_rd,
	output video_pkg::mem_addr_t   mem_addr,
	input  logic                   mem_valid,
	input  logic [31:0]            mem_data,
	output video_pkg::video_word_u cur_word
);

	video_pkg::mem_addr_t   line_cnt;
	video_pkg::grp_t        grp_cnt;
	video_pkg::mem_addr_t   rd_addr;
	logic                   pending;
	video_pkg::video_word_u next_q;
	video_pkg::video_word_u cur_q;

	// line * groups per line + group, same in every mode
	assign rd_addr = video_pkg::mem_addr_t'(line_cnt * video_pkg::GROUPS) +
		video_pkg::mem_addr_t'(grp_cnt);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_rd   <= 1'b0;
			pending  <= 1'b0;
			line_cnt <= '0;
			grp_cnt  <= '0;
		end else begin
			mem_rd <= fetch_req;
			if (mem_rd)
				pending <= 1'b1;
			else if (mem_valid)
				pending <= 1'b0;

			// first frame after reset is a warm-up until vsync aligns the lines
			if (vsync) begin
				line_cnt <= '0;
				grp_cnt  <= '0;
			end else if (line_start) begin
				grp_cnt <= '0;
			end else if (fetch_req) begin
				if (grp_cnt == video_pkg::grp_t'(video_pkg::GROUPS - 1)) begin
					grp_cnt  <= '0;
					line_cnt <= line_cnt + 1'b1;
				end else begin
					grp_cnt <= grp_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_req)
			mem_addr <= rd_addr;
		if (mem_valid)
			next_q <= mem_data;
		if (group_tick)
			cur_q <= next_q;
	end

	// new word is visible on the first pixel of its group
	assign cur_word = group_tick ? next_q : cur_q;

	a_valid_pending: assert property (@(posedge clk) disable iff (!rst_n)
		mem_valid |-> pending)
		else $error("memory answered with no read outstanding");

	a_word_ready: assert property (@(posedge clk) disable iff (!rst_n)
		group_tick |-> !pending)
		else $error("video word still outstanding at the group boundary");

endmodule

//--- hdl/video_render.sv
// pixel renderer: decodes the current word per mode, muxes border and overlay, packs hi-res
module video_render (
	input  logic                   clk,
	input  logic                   rst_n,
	input  video_pkg::video_cfg_s  cfg,
	input  video_pkg::raster_s     raster,
	input  video_pkg::video_word_u word,
	input  logic [7:0]             overlay,
	output logic [7:0]             index
);

	logic       zx_dot;
	logic [7:0] zx_attr;
	logic [2:0] zx_col;
	logic [7:0] zx_pix;
	logic [7:0] tx_pix;
	logic [7:0] hc_byte;
	logic [3:0] hc_nib;
	logic [7:0] hc_pix;
	logic [7:0] xc_pix;
	logic [7:0] mode_pix;
	logic [7:0] video;
	logic [3:0] nib_q;

	// bitmap is MSB first within each byte
	assign zx_dot  = word.zx.gfx[{raster.psel[3], ~raster.psel[2:0]}];
	assign zx_attr = raster.psel[3] ? word.zx.atr[15:8] : word.zx.atr[7:0];

	// ink on a set dot, swapped while flashing
	assign zx_col = (zx_dot ^ (cfg.flash & zx_attr[7])) ? zx_attr[2:0] : zx_attr[5:3];
	assign zx_pix = {cfg.palsel, zx_attr[6], zx_col};

	// text shares the ZX bitmap, attribute holds two nibble colours
	assign tx_pix = {cfg.palsel, zx_dot ? zx_attr[3:0] : zx_attr[7:4]};

	// 16c, high nibble is the left pixel
	assign hc_byte = word.chunky[raster.psel[1]];
	assign hc_nib  = raster.psel[0] ? hc_byte[3:0] : hc_byte[7:4];
	assign hc_pix  = {cfg.palsel, hc_nib};

	assign xc_pix = word.chunky[raster.psel[0]];

	always_comb begin
		unique case (cfg.mode)
			video_pkg::R_ZX: mode_pix = zx_pix;
			video_pkg::R_HC: mode_pix = hc_pix;
			video_pkg::R_XC: mode_pix = xc_pix;
			video_pkg::R_TX: mode_pix = tx_pix;
		endcase
	end

	// border, then overlay, then nogfx blanking, then graphics
	always_comb begin
		if (!raster.hvpix)
			video = cfg.border;
		else if ((|overlay[3:0]) && !cfg.notsu)
			video = overlay;
		else if (cfg.nogfx)
			video = cfg.border;
		else
			video = mode_pix;
	end

	// in hi-res one index carries two 4-bit pixels
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			nib_q <= '0;
			index <= '0;
		end else begin
			if (raster.phase)
				nib_q <= video[3:0];
			index <= cfg.hires ? {nib_q, video[3:0]} : video;
		end
	end

endmodule

//--- hdl/video_palette.sv
// colour palette: host-writable 256 x 16 table with a registered lookup and blanking
module video_palette (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        pal_we,
	input  logic [7:0]  pal_addr,
	input  logic [15:0] pal_data,
	input  logic [7:0]  index,
	input  logic        de,
	output logic [15:0] rgb
);

	logic [15:0] ram [256];
	logic [15:0] rgb_q;

	// host write, visible to lookups from the next cycle
	always_ff @(posedge clk) begin
		if (pal_we)
			ram[pal_addr] <= pal_data;
	end

	// lookup stage, second register of the pixel path
	always_ff @(posedge clk) begin
		if (!rst_n)
			rgb_q <= '0;
		else
			rgb_q <= ram[index];
	end

	// black outside the displayed area
	assign rgb = de ? rgb_q : '0;

endmodule

//--- hdl/video_out.sv
// video output top: raster timing, word fetch, renderer and palette wired to the pins
module video_out (
	input  logic                  clk,
	input  logic                  rst_n,
	input  video_pkg::video_cfg_s cfg,
	input  logic [7:0]            overlay,

	// video memory port
	output logic                  mem_rd,
	output video_pkg::mem_addr_t  mem_addr,
	input  logic                  mem_valid,
	input  logic [31:0]           mem_data,

	// palette host port
	input  logic                  pal_we,
	input  logic [7:0]            pal_addr,
	input  logic [15:0]           pal_data,

	output logic                  hsync,
	output logic                  vsync,
	output logic                  de,
	output logic [15:0]           rgb
);

	video_pkg::raster_s     raster;
	video_pkg::video_word_u cur_word;
	logic                   fetch_req;
	logic                   group_tick;
	logic                   line_start;
	logic [7:0]             index;

	video_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.raster     (raster),
		.fetch_req  (fetch_req),
		.group_tick (group_tick),
		.line_start (line_start),
		.hsync      (hsync),
		.vsync      (vsync),
		.de         (de)
	);

	video_fetch u_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.fetch_req  (fetch_req),
		.group_tick (group_tick),
		.line_start (line_start),
		.vsync      (vsync),
		.mem_rd     (mem_rd),
		.mem_addr   (mem_addr),
		.mem_valid  (mem_valid),
		.mem_data   (mem_data),
		.cur_word   (cur_word)
	);

	video_render u_render (
		.clk     (clk),
		.rst_n   (rst_n),
		.cfg     (cfg),
		.raster  (raster),
		.word    (cur_word),
		.overlay (overlay),
		.index   (index)
	);

	video_palette u_palette (
		.clk      (clk),
		.rst_n    (rst_n),
		.pal_we   (pal_we),
		.pal_addr (pal_addr),
		.pal_data (pal_data),
		.index    (index),
		.de       (de),
		.rgb      (rgb)
	);

endmodule

//--- tests/tb_clock.sv
// testbench clock source, one instance in the testbench top drives every clocked block
module tb_clock (
	output logic clk
);

	initial clk = 1'b0;

	// period of 20
	always #10 clk = ~clk;

endmodule

//--- tests/video_out_checker.sv
// testbench monitor that the testbench top instantiates to predict each displayed pixel
module video_out_checker (
	input  logic                  clk,
	input  logic                  rst_n,
	input  video_pkg::video_cfg_s cfg,
	input  logic [7:0]            overlay,
	input  logic                  mem_rd,
	input  video_pkg::mem_addr_t  mem_addr,
	input  logic                  hsync,
	input  logic                  vsync,
	input  logic                  de,
	input  logic [15:0]           rgb,
	input  int                    test_id,
	output int                    errors,
	output int                    pixels
);

	video_pkg::video_cfg_s cfg_d1;
	video_pkg::video_cfg_s cfg_d2;
	logic [7:0]            ov_d1;
	logic [7:0]            ov_d2;
	logic [7:0]            vid_line [video_pkg::H_ACTIVE];
	bit                    armed;
	bit                    hs_prev;
	bit                    vs_prev;
	bit                    de_prev;
	int                    x;
	int                    y;
	int                    hs_rises;
	int                    vs_cycles;
	int                    de_cycles;
	int                    rd_cnt;
	int                    frame_err;
	int                    frame_pix;

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED t=%0t %s: expected %0h, got %0h", $time, name, expected, actual);
			errors++;
			frame_err++;
		end
	endtask

	// word address is line * words per line + group
	function automatic logic [31:0] word_at(int px, int py);
		return video_out_tb.mem[py * (video_pkg::H_ACTIVE / video_pkg::GROUP_PIX) +
			px / video_pkg::GROUP_PIX];
	endfunction

	function automatic logic [7:0] mode_pixel(video_pkg::video_cfg_s c, logic [31:0] w,
		int px, int py);
		int         half;
		int         p;
		logic [7:0] gfx;
		logic [7:0] atr;
		logic [7:0] bv;
		logic       dot;
		logic       ink_on;
		logic [7:0] pix;
		// odd lines use the upper bitmap byte and attribute
		half   = py % 2;
		gfx    = w[half * 8 +: 8];
		atr    = w[16 + half * 8 +: 8];
		dot    = gfx[7 - (px % 8)];
		ink_on = (c.flash && atr[7]) ? !dot : dot;
		case (c.mode)
			video_pkg::R_ZX: pix = {c.palsel, atr[6], ink_on ? atr[2:0] : atr[5:3]};
			video_pkg::R_TX: pix = {c.palsel, dot ? atr[3:0] : atr[7:4]};
			video_pkg::R_HC: begin
				// four nibbles per group shown twice each with the high nibble first
				p   = (px % 8) / 2;
				bv  = w[(p / 2) * 8 +: 8];
				pix = {c.palsel, (p % 2 == 0) ? bv[7:4] : bv[3:0]};
			end
			default: begin
				p   = (px % 8) / 4;
				pix = w[p * 8 +: 8];
			end
		endcase
		return pix;
	endfunction

	function automatic logic [7:0] mix_layers(video_pkg::video_cfg_s c, logic [7:0] ov,
		logic [7:0] pix);
		if (ov[3:0] != 4'h0 && !c.notsu)
			return ov;
		else if (c.nogfx)
			return c.border;
		return pix;
	endfunction

	task automatic check_pixel(input video_pkg::video_cfg_s c, input logic [7:0] ov);
		logic [7:0] vid;
		logic [3:0] prev_nib;
		logic [7:0] idx;
		vid         = mix_layers(c, ov, mode_pixel(c, word_at(x, y), x, y));
		vid_line[x] = vid;
		// hi-res pairs with the last even pixel and with the border before pixel 0
		if (x == 0)
			prev_nib = c.border[3:0];
		else if (x % 2 == 1)
			prev_nib = vid_line[x - 1][3:0];
		else
			prev_nib = vid_line[x - 2][3:0];
		idx = c.hires ? {prev_nib, vid[3:0]} : vid;
		compare_value($sformatf("rgb (x %0d, y %0d)", x, y), video_out_tb.pal_table[idx], rgb);
		pixels++;
		frame_pix++;
	endtask

	task automatic close_frame(input video_pkg::video_cfg_s c);
		compare_value("hsync pulses per frame", video_pkg::V_TOTAL, hs_rises);
		compare_value("vsync cycles per frame", video_pkg::VSYNC_LEN * video_pkg::H_TOTAL,
			vs_cycles);
		compare_value("de cycles per frame", video_pkg::V_ACTIVE * video_pkg::H_ACTIVE, de_cycles);
		compare_value("memory reads per frame", video_pkg::V_ACTIVE * video_pkg::GROUPS, rd_cnt);
		$display("test %0d (mode %0d hires %0b nogfx %0b notsu %0b flash %0b): %0d pixels, %0d errors",
			test_id, c.mode, c.hires, c.nogfx, c.notsu, c.flash, frame_pix, frame_err);
	endtask

	// outputs settle after the rising edge, so look at them on the falling one
	always @(negedge clk) begin : watch
		video_pkg::video_cfg_s c;
		logic [7:0]            ov;
		c      = cfg_d2;
		ov     = ov_d2;
		cfg_d2 = cfg_d1;
		cfg_d1 = cfg;
		ov_d2  = ov_d1;
		ov_d1  = overlay;
		if (!rst_n) begin
			armed = 1'b0;
			compare_value("de in reset", 0, de);
			compare_value("hsync in reset", 0, hsync);
			compare_value("vsync in reset", 0, vsync);
			compare_value("mem_rd in reset", 0, mem_rd);
			compare_value("rgb in reset", 0, rgb);
		end else begin
			// frames run from one vsync to the next
			if (vsync && !vs_prev) begin
				if (armed)
					close_frame(c);
				armed     = 1'b1;
				x         = 0;
				y         = 0;
				hs_rises  = 0;
				vs_cycles = 0;
				de_cycles = 0;
				rd_cnt    = 0;
				frame_err = 0;
				frame_pix = 0;
			end
			if (hsync && !hs_prev)
				hs_rises++;
			if (vsync)
				vs_cycles++;
			// words are read line by line in group order
			if (armed && mem_rd) begin
				compare_value("mem_addr", rd_cnt, mem_addr);
				rd_cnt++;
			end
			if (de) begin
				de_cycles++;
				if (armed && (x >= video_pkg::H_ACTIVE || y >= video_pkg::V_ACTIVE)) begin
					$display("display enable seen outside the active area at t=%0t", $time);
					errors++;
					frame_err++;
				end else if (armed) begin
					check_pixel(c, ov);
				end
				x++;
			end else begin
				if (armed)
					compare_value("rgb while de low", 0, rgb);
				if (de_prev) begin
					x = 0;
					y++;
				end
			end
		end
		hs_prev = hsync;
		vs_prev = vsync;
		de_prev = de;
	end

endmodule

//--- tests/video_out_tb.sv
// testbench top that runs video_out through a table of display modes with a modelled memory
module video_out_tb;

	typedef struct packed {
		video_pkg::video_cfg_s cfg;
		logic [1:0]            ov_mode;	// 0 no overlay, 1 mixed overlay
	} test_entry_s;

	logic                  clk;
	logic                  rst_n;
	video_pkg::video_cfg_s cfg;
	logic [7:0]            overlay = 8'h00;
	logic                  mem_rd;
	video_pkg::mem_addr_t  mem_addr;
	logic                  mem_valid = 1'b0;
	logic [31:0]           mem_data = 32'h0;
	logic                  pal_we;
	logic [7:0]            pal_addr;
	logic [15:0]           pal_data;
	logic                  hsync;
	logic                  vsync;
	logic                  de;
	logic [15:0]           rgb;

	logic [31:0]           mem [256];
	logic [15:0]           pal_table [256];
	test_entry_s           tests [$];
	logic [1:0]            ov_mode = 2'd0;
	int                    test_id;
	int                    errors;
	int                    pixels;
	int                    rd_wait;
	video_pkg::mem_addr_t  rd_addr_q;
	bit                    timed_out;

	tb_clock u_clock (.clk(clk));

	video_out u_video_out (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.overlay   (overlay),
		.mem_rd    (mem_rd),
		.mem_addr  (mem_addr),
		.mem_valid (mem_valid),
		.mem_data  (mem_data),
		.pal_we    (pal_we),
		.pal_addr  (pal_addr),
		.pal_data  (pal_data),
		.hsync     (hsync),
		.vsync     (vsync),
		.de        (de),
		.rgb       (rgb)
	);

	video_out_checker u_checker (
		.clk      (clk),
		.rst_n    (rst_n),
		.cfg      (cfg),
		.overlay  (overlay),
		.mem_rd   (mem_rd),
		.mem_addr (mem_addr),
		.hsync    (hsync),
		.vsync    (vsync),
		.de       (de),
		.rgb      (rgb),
		.test_id  (test_id),
		.errors   (errors),
		.pixels   (pixels)
	);

	// video memory answers each read 1 to 6 cycles after the strobe
	always @(posedge clk) begin : mem_model
		int lat;
		mem_valid <= 1'b0;
		if (!rst_n) begin
			rd_wait = 0;
		end else if (mem_rd) begin
			lat = 1 + int'($urandom % 6);
			if (lat == 1) begin
				mem_valid <= 1'b1;
				mem_data  <= mem[mem_addr];
			end else begin
				rd_wait   = lat - 1;
				rd_addr_q = mem_addr;
			end
		end else if (rd_wait > 0) begin
			rd_wait = rd_wait - 1;
			if (rd_wait == 0) begin
				mem_valid <= 1'b1;
				mem_data  <= mem[rd_addr_q];
			end
		end
	end

	// mixed overlay with about a quarter of the pixels opaque
	always @(posedge clk) begin : overlay_drive
		logic [31:0] r;
		r = $urandom;
		if (ov_mode == 2'd0)
			overlay <= 8'h00;
		else if (r[9:8] == 2'b00)
			overlay <= r[7:0];
		else
			overlay <= {r[7:4], 4'h0};
	end

	task automatic add_test(input video_pkg::render_mode_e mode, input logic hires,
		input logic nogfx, input logic notsu, input logic flash, input logic [3:0] palsel,
		input logic [7:0] border, input logic [1:0] ov);
		test_entry_s t;
		t.cfg.mode   = mode;
		t.cfg.hires  = hires;
		t.cfg.nogfx  = nogfx;
		t.cfg.notsu  = notsu;
		t.cfg.flash  = flash;
		t.cfg.palsel = palsel;
		t.cfg.border = border;
		t.ov_mode    = ov;
		tests.push_back(t);
	endtask

	task automatic load_palette();
		for (int i = 0; i < 256; i++) begin
			@(posedge clk);
			pal_we   <= 1'b1;
			pal_addr <= 8'(i);
			pal_data <= pal_table[i];
		end
		@(posedge clk);
		pal_we <= 1'b0;
	endtask

	task automatic wait_first_de(output bit ok);
		int n;
		ok = 1'b0;
		n  = 0;
		while (!ok && n < video_pkg::H_TOTAL * video_pkg::V_TOTAL) begin
			@(posedge clk);
			ok = de;
			n++;
		end
	endtask

	task automatic wait_vsync_rise(output bit ok);
		int n;
		bit prev;
		ok   = 1'b0;
		n    = 0;
		prev = vsync;
		while (!ok && n < 2 * video_pkg::H_TOTAL * video_pkg::V_TOTAL) begin
			@(posedge clk);
			ok   = vsync && !prev;
			prev = vsync;
			n++;
		end
	endtask

	initial begin : main
		bit ok;
		int n_exp;
		void'($urandom(74));
		rst_n     = 1'b0;
		cfg       = '0;
		pal_we    = 1'b0;
		pal_addr  = 8'h00;
		pal_data  = 16'h0000;
		test_id   = 0;
		timed_out = 1'b0;
		for (int i = 0; i < 256; i++) begin
			mem[i]       = $urandom;
			pal_table[i] = 16'($urandom);
		end

		//       mode              hi   nogfx notsu flash pal    border ov
		add_test(video_pkg::R_ZX, 1'b0, 1'b0, 1'b0, 1'b0, 4'h0, 8'h11, 2'd0);
		add_test(video_pkg::R_ZX, 1'b0, 1'b0, 1'b0, 1'b1, 4'h3, 8'h22, 2'd0);
		add_test(video_pkg::R_TX, 1'b0, 1'b0, 1'b0, 1'b0, 4'h5, 8'h33, 2'd0);
		add_test(video_pkg::R_HC, 1'b0, 1'b0, 1'b0, 1'b0, 4'h9, 8'h44, 2'd0);
		add_test(video_pkg::R_XC, 1'b0, 1'b0, 1'b0, 1'b0, 4'h0, 8'h55, 2'd0);
		add_test(video_pkg::R_XC, 1'b0, 1'b0, 1'b0, 1'b0, 4'h0, 8'h66, 2'd1);
		add_test(video_pkg::R_HC, 1'b0, 1'b0, 1'b1, 1'b0, 4'h2, 8'h77, 2'd1);
		add_test(video_pkg::R_ZX, 1'b0, 1'b1, 1'b0, 1'b0, 4'h1, 8'h5a, 2'd0);
		add_test(video_pkg::R_TX, 1'b0, 1'b1, 1'b0, 1'b0, 4'h6, 8'ha5, 2'd1);
		add_test(video_pkg::R_ZX, 1'b1, 1'b0, 1'b0, 1'b1, 4'h7, 8'h3c, 2'd0);
		add_test(video_pkg::R_HC, 1'b1, 1'b0, 1'b0, 1'b0, 4'hc, 8'hc3, 2'd1);

		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		wait_first_de(ok);
		if (!ok) begin
			$display("timeout: no display enable within one frame after reset");
			timed_out = 1'b1;
		end else begin
			load_palette();
		end

		// each entry takes effect at vsync and covers the whole next frame
		for (int i = 0; i < tests.size() && !timed_out; i++) begin
			wait_vsync_rise(ok);
			if (!ok) begin
				$display("timeout: vsync did not arrive before test %0d", i);
				timed_out = 1'b1;
			end else begin
				cfg     <= tests[i].cfg;
				ov_mode <= tests[i].ov_mode;
				test_id <= i;
			end
		end
		if (!timed_out) begin
			wait_vsync_rise(ok);
			if (!ok) begin
				$display("timeout: vsync did not arrive after the last test");
				timed_out = 1'b1;
			end
		end
		@(posedge clk);

		n_exp = tests.size() * video_pkg::V_ACTIVE * video_pkg::H_ACTIVE;
		$display("summary: %0d tests, %0d pixels checked, %0d errors", tests.size(), pixels, errors);
		if (!timed_out && pixels != n_exp)
			$display("only %0d of %0d expected pixels were checked", pixels, n_exp);
		if (!timed_out && errors == 0 && pixels == n_exp)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- video_out.f
hdl/video_pkg.sv
hdl/video_ctrl.sv
hdl/video_fetch.sv
hdl/video_render.sv
hdl/video_palette.sv
hdl/video_out.sv
tests/tb_clock.sv
tests/video_out_checker.sv
tests/video_out_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the video_out testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module video_out_tb \
	-f video_out.f -o sim_video_out
./obj_dir/sim_video_out | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failures"
